// File: src.f
+incdir+.
soc_pkg.sv
key_irq.sv
sector_buffer.sv
ram_port.sv
bus_ctrl.sv
soc_bus_top.sv
tb_soc.sv

// File: run.sh
#!/bin/sh
# build the simulation with verilator, run it and check the log
set -e
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_soc -f src.f -o tb_soc_sim
./obj_dir/tb_soc_sim > sim.log 2>&1
cat sim.log
if grep -q "^TESTS PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb_model.svh
// shadow copies of the ram and of the last streamed sector
logic [31:0] shadow_mem [ram_words];
logic [7:0]  shadow_sector [sector_bytes];

// ram comes up all zero
task automatic model_clear();
    for (int i = 0; i < ram_words; i++) begin
        shadow_mem[i] = '0;
    end
endtask

// apply one store to the shadow ram
task automatic shadow_store(input logic [63:0] addr, input ls_type_u t,
                            input logic [63:0] data);
    int idx;
    int off;
    idx = int'(addr[13:2]);
    off = int'(addr[1:0]);
    case (t.raw)
        3'd0: begin
            shadow_mem[idx][off*8 +: 8] = data[7:0];
        end
        3'd1: begin
            // halfwords land at offset 0 or 2 only
            if (off % 2 == 0) begin
                shadow_mem[idx][off*8 +: 16] = data[15:0];
            end
        end
        3'd2: begin
            shadow_mem[idx] = data[31:0];
        end
        3'd3: begin
            // high half goes one word up
            shadow_mem[idx] = data[31:0];
            shadow_mem[idx + 1] = data[63:32];
        end
        default: begin
        end
    endcase
endtask

// expected load data for a ram address and load type
function automatic logic [63:0] expected_read(input logic [63:0] addr, input ls_type_u t);
    int          idx;
    int          off;
    logic [31:0] w;
    idx = int'(addr[13:2]);
    off = int'(addr[1:0]);
    if (t.raw == 3'd3) begin
        // low word first, then the next word
        expected_read = {shadow_mem[idx + 1], shadow_mem[idx]};
    end else begin
        // shifted down by the byte offset, no narrowing
        w = shadow_mem[idx] >> (off * 8);
        expected_read = {32'b0, w};
    end
endfunction

// File: tb_soc.sv
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

    logic              CLOCK_50;
    logic              KEY0;
    logic [addr_w-1:0] bus_addr;
    logic [data_w-1:0] bus_wdata;
    ls_type_u          bus_ls_type;
    logic              bus_rd_en;
    logic              bus_wr_en;
    logic [7:0]        key_ascii;
    logic              key_pressed;
    logic              irq_ack;
    logic              sd_ready;
    logic [7:0]        sd_byte;
    logic              sd_byte_valid;
    logic [data_w-1:0] bus_rdata;
    logic              bus_rd_done;
    logic              bus_wr_done;
    logic [7:0]        uart_data;
    logic              uart_valid;
    logic [3:0]        irq_vector;
    logic [31:0]       sd_sector;
    logic              sd_read_start;

    integer seed;
    int     checks;
    int     errors;
    int     checks_at_start;
    int     errors_at_start;

    // pending read compare
    logic        rd_armed;
    logic        rd_done_q;
    logic [63:0] exp_rdata;
    string       exp_name;

    // strobe monitor
    int          uart_pulses;
    logic [7:0]  uart_seen;
    int          sd_pulses;

    `include "tb_model.svh"

    soc_bus_top u_soc_bus_top (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_ls_type   (bus_ls_type),
        .bus_rd_en     (bus_rd_en),
        .bus_wr_en     (bus_wr_en),
        .key_ascii     (key_ascii),
        .key_pressed   (key_pressed),
        .irq_ack       (irq_ack),
        .sd_ready      (sd_ready),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid),
        .bus_rdata     (bus_rdata),
        .bus_rd_done   (bus_rd_done),
        .bus_wr_done   (bus_wr_done),
        .uart_data     (uart_data),
        .uart_valid    (uart_valid),
        .irq_vector    (irq_vector),
        .sd_sector     (sd_sector),
        .sd_read_start (sd_read_start)
    );

    // 100 ns clock
    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("t=%0t failure: %s", $time, what);
    endtask

    // compare read data on the negedge after done rises
    always @(negedge CLOCK_50) begin
        if (rd_armed && !rd_done_q && bus_rd_done) begin
            check_value(exp_name, exp_rdata, bus_rdata);
            rd_armed = 1'b0;
        end
        rd_done_q = bus_rd_done;
    end

    // count single cycle strobes
    always @(negedge CLOCK_50) begin
        if (uart_valid) begin
            uart_pulses++;
            uart_seen = uart_data;
        end
        if (sd_read_start) begin
            sd_pulses++;
        end
    end

    // inputs change 5 ns after the rising edge
    task automatic next_slot();
        @(posedge CLOCK_50);
        #5;
    endtask

    task automatic wait_done(input bit is_read);
        int n;
        n = 0;
        @(negedge CLOCK_50);
        // flag drops on the edge that took the enable
        if (is_read ? bus_rd_done : bus_wr_done) begin
            note_failure(is_read ? "read done did not fall" : "write done did not fall");
        end
        while ((is_read ? !bus_rd_done : !bus_wr_done) && n < 20) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (is_read ? !bus_rd_done : !bus_wr_done) begin
            note_failure(is_read ? "read done never rose" : "write done never rose");
        end
    endtask

    task automatic wait_irq(input logic [3:0] target);
        int n;
        n = 0;
        @(negedge CLOCK_50);
        while (irq_vector !== target && n < 10) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (irq_vector !== target) begin
            note_failure("irq_vector did not reach the expected value");
        end
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [2:0] code,
                             input logic [63:0] data);
        next_slot();
        bus_addr = addr;
        bus_wdata = data;
        bus_ls_type.raw = code;
        bus_wr_en = 1'b1;
        next_slot();
        bus_wr_en = 1'b0;
        wait_done(1'b0);
    endtask

    task automatic bus_read(input logic [63:0] addr, input logic [2:0] code,
                            input logic [63:0] exp);
        next_slot();
        bus_addr = addr;
        bus_ls_type.raw = code;
        exp_rdata = exp;
        exp_name = $sformatf("bus_rdata @%h", addr);
        rd_armed = 1'b1;
        bus_rd_en = 1'b1;
        next_slot();
        bus_rd_en = 1'b0;
        wait_done(1'b1);
        // let the compare process see this edge first
        #1;
        rd_armed = 1'b0;
    endtask

    task automatic stream_byte(input logic [7:0] b);
        next_slot();
        sd_byte = b;
        sd_byte_valid = 1'b1;
        next_slot();
        sd_byte_valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        $display("test %-10s %0d checks, %0d errors", name,
                 checks - checks_at_start, errors - errors_at_start);
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    initial begin
        int          idx;
        logic [1:0]  off;
        logic [2:0]  code;
        logic [63:0] addr;
        logic [63:0] data;
        logic [7:0]  ch;
        int          pos;
        seed = 32'h67e4;
        checks = 0;
        errors = 0;
        checks_at_start = 0;
        errors_at_start = 0;
        rd_armed = 1'b0;
        rd_done_q = 1'b1;
        uart_pulses = 0;
        uart_seen = '0;
        sd_pulses = 0;
        KEY0 = 1'b0;
        bus_addr = '0;
        bus_wdata = '0;
        bus_ls_type.raw = 3'd0;
        bus_rd_en = 1'b0;
        bus_wr_en = 1'b0;
        key_ascii = '0;
        key_pressed = 1'b0;
        irq_ack = 1'b0;
        sd_ready = 1'b0;
        sd_byte = '0;
        sd_byte_valid = 1'b0;
        model_clear();

        // reset for 16 clocks
        repeat (16) @(posedge CLOCK_50);
        #5;
        KEY0 = 1'b1;

        // ram: random sized stores, then loads around them
        for (int n = 0; n < 40; n++) begin
            // word 1..3068 keeps neighbour doubles inside the array
            idx = 1 + int'($unsigned($random(seed)) % 3068);
            code = 3'($unsigned($random(seed)) % 4);
            off = 2'($random(seed));
            if (code == 3'd1) begin
                off[0] = 1'b0;
            end else if (code >= 3'd2) begin
                off = 2'd0;
            end
            addr = 64'(idx) * 4 + 64'(off);
            data = {$random(seed), $random(seed)};
            bus_write(addr, code, data);
            shadow_store(addr, code, data);
            for (int t = 0; t < 7; t++) begin
                bus_read(addr, 3'(t), expected_read(addr, 3'(t)));
            end
            code = 3'($unsigned($random(seed)) % 7);
            bus_read(addr - 4, code, expected_read(addr - 4, code));
            code = 3'($unsigned($random(seed)) % 7);
            bus_read(addr + 4, code, expected_read(addr + 4, code));
        end
        end_test("ram");

        // console byte strobe
        next_slot();
        uart_pulses = 0;
        data = {$random(seed), $random(seed)};
        bus_write(uart_addr, 3'd0, data);
        repeat (2) next_slot();
        check_value("uart_valid pulses", 64'd1, 64'(uart_pulses));
        check_value("uart_data", 64'(data[7:0]), 64'(uart_seen));
        end_test("uart");

        // keyboard latch, vector and acknowledge
        ch = 8'h41 + 8'($unsigned($random(seed)) % 26);
        next_slot();
        key_ascii = ch;
        key_pressed = 1'b1;
        wait_irq(4'd1);
        check_value("irq_vector", 64'd1, 64'(irq_vector));
        next_slot();
        key_pressed = 1'b0;
        bus_read(key_addr, 3'd2, 64'(ch));
        next_slot();
        irq_ack = 1'b1;
        next_slot();
        irq_ack = 1'b0;
        wait_irq(4'd0);
        check_value("irq_vector", 64'd0, 64'(irq_vector));
        // null character press
        next_slot();
        key_ascii = 8'd0;
        key_pressed = 1'b1;
        repeat (3) next_slot();
        check_value("irq_vector", 64'd0, 64'(irq_vector));
        key_pressed = 1'b0;
        bus_read(key_addr, 3'd2, 64'd0);
        end_test("keyboard");

        // sd sector address, read start and ready
        data = {$random(seed), $random(seed)};
        bus_write(sdc_addr_reg, 3'd3, data);
        check_value("sd_sector", 64'(data[31:0]), 64'(sd_sector));
        next_slot();
        sd_pulses = 0;
        bus_write(sdc_read_reg, 3'd3, 64'd1);
        repeat (2) next_slot();
        check_value("sd_read_start pulses", 64'd1, 64'(sd_pulses));
        sd_ready = 1'b1;
        bus_read(sdc_ready_reg, 3'd2, 64'd1);
        next_slot();
        sd_ready = 1'b0;
        bus_read(sdc_ready_reg, 3'd2, 64'd0);
        end_test("sd_regs");

        // full sector stream
        for (int i = 0; i < sector_bytes; i++) begin
            shadow_sector[i] = 8'($random(seed));
            stream_byte(shadow_sector[i]);
        end
        bus_read(sdc_avail_reg, 3'd2, 64'd1);
        bus_read(sdc_buf_base, 3'd2, 64'(shadow_sector[0]));
        bus_read(sdc_buf_base + 1, 3'd0, 64'(shadow_sector[1]));
        bus_read(sdc_buf_base + 255, 3'd4, 64'(shadow_sector[255]));
        bus_read(sdc_buf_base + 511, 3'd3, 64'(shadow_sector[511]));
        for (int i = 0; i < 8; i++) begin
            pos = int'($unsigned($random(seed)) % sector_bytes);
            bus_read(sdc_buf_base + 64'(pos), 3'd2, 64'(shadow_sector[pos]));
        end
        // first byte of the next sector drops the flag
        stream_byte(8'($random(seed)));
        bus_read(sdc_avail_reg, 3'd2, 64'd0);
        end_test("sector");

        // holes in the map read zero and still finish
        // ready reads 1 between holes so every zero is fresh data
        next_slot();
        sd_ready = 1'b1;
        bus_read(sdc_ready_reg, 3'd2, 64'd1);
        bus_read(64'h3000, 3'd2, 64'd0);
        bus_read(sdc_ready_reg, 3'd2, 64'd1);
        bus_read(64'h7ffc, 3'd3, 64'd0);
        bus_read(sdc_ready_reg, 3'd2, 64'd1);
        bus_read(64'h8004, 3'd2, 64'd0);
        bus_read(sdc_ready_reg, 3'd2, 64'd1);
        bus_read(64'h8030, 3'd2, 64'd0);
        bus_read(sdc_ready_reg, 3'd2, 64'd1);
        bus_read(64'h9200, 3'd0, 64'd0);
        bus_read(sdc_ready_reg, 3'd2, 64'd1);
        bus_read(64'h1_0000_0000, 3'd3, 64'd0);
        bus_write(64'h3000, 3'd2, {$random(seed), $random(seed)});
        bus_write(64'h8030, 3'd3, {$random(seed), $random(seed)});
        bus_write(64'h9200, 3'd0, {$random(seed), $random(seed)});
        end_test("unmapped");

        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top import soc_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic [addr_w-1:0] bus_addr,
    input  logic [data_w-1:0] bus_wdata,
    input  ls_type_u          bus_ls_type,
    input  logic              bus_rd_en,
    input  logic              bus_wr_en,
    input  logic [7:0]        key_ascii,
    input  logic              key_pressed,
    input  logic              irq_ack,
    input  logic              sd_ready,
    input  logic [7:0]        sd_byte,
    input  logic              sd_byte_valid,
    output logic [data_w-1:0] bus_rdata,
    output logic              bus_rd_done,
    output logic              bus_wr_done,
    output logic [7:0]        uart_data,
    output logic              uart_valid,
    output logic [3:0]        irq_vector,
    output logic [31:0]       sd_sector,
    output logic              sd_read_start
);

    // keyboard to bus
    logic [7:0]            key_char;

    // sector buffer to bus
    logic [7:0]            buf_byte;
    logic                  sector_avail;
    logic [buf_idx_w-1:0]  buf_index;

    // bus to ram
    logic                  ram_start;
    logic                  ram_write;
    logic [ram_addr_w-1:0] ram_addr;
    ls_type_u              ram_type;
    logic [data_w-1:0]     ram_wdata;
    logic [data_w-1:0]     ram_rdata;
    logic                  ram_done;

    // handshake, decode and register file
    bus_ctrl u_bus_ctrl (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_ls_type   (bus_ls_type),
        .bus_rd_en     (bus_rd_en),
        .bus_wr_en     (bus_wr_en),
        .key_char      (key_char),
        .sd_ready      (sd_ready),
        .buf_byte      (buf_byte),
        .sector_avail  (sector_avail),
        .ram_rdata     (ram_rdata),
        .ram_done      (ram_done),
        .bus_rdata     (bus_rdata),
        .bus_rd_done   (bus_rd_done),
        .bus_wr_done   (bus_wr_done),
        .uart_data     (uart_data),
        .uart_valid    (uart_valid),
        .sd_sector     (sd_sector),
        .sd_read_start (sd_read_start),
        .buf_index     (buf_index),
        .ram_start     (ram_start),
        .ram_write     (ram_write),
        .ram_addr      (ram_addr),
        .ram_type      (ram_type),
        .ram_wdata     (ram_wdata)
    );

    ram_port u_ram_port (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ram_start (ram_start),
        .ram_write (ram_write),
        .ram_addr  (ram_addr),
        .ram_type  (ram_type),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .ram_done  (ram_done)
    );

    key_irq u_key_irq (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_ascii   (key_ascii),
        .key_pressed (key_pressed),
        .irq_ack     (irq_ack),
        .key_char    (key_char),
        .irq_vector  (irq_vector)
    );

    // sd byte stream capture
    sector_buffer u_sector_buffer (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid),
        .buf_index     (buf_index),
        .buf_byte      (buf_byte),
        .sector_avail  (sector_avail)
    );

endmodule

// File: bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl import soc_pkg::*; (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic [addr_w-1:0]     bus_addr,
    input  logic [data_w-1:0]     bus_wdata,
    input  ls_type_u              bus_ls_type,
    input  logic                  bus_rd_en,
    input  logic                  bus_wr_en,
    input  logic [7:0]            key_char,
    input  logic                  sd_ready,
    input  logic [7:0]            buf_byte,
    input  logic                  sector_avail,
    input  logic [data_w-1:0]     ram_rdata,
    input  logic                  ram_done,
    output logic [data_w-1:0]     bus_rdata,
    output logic                  bus_rd_done,
    output logic                  bus_wr_done,
    output logic [7:0]            uart_data,
    output logic                  uart_valid,
    output logic [31:0]           sd_sector,
    output logic                  sd_read_start,
    output logic [buf_idx_w-1:0]  buf_index,
    output logic                  ram_start,
    output logic                  ram_write,
    output logic [ram_addr_w-1:0] ram_addr,
    output ls_type_u              ram_type,
    output logic [data_w-1:0]     ram_wdata
);

    logic              ram_hit;
    logic              key_hit;
    logic              uart_hit;
    logic              sdc_addr_hit;
    logic              sdc_read_hit;
    logic              ready_hit;
    logic              avail_hit;
    logic              buf_hit;
    logic [addr_w-1:0] buf_off;
    logic [data_w-1:0] reg_rdata;
    logic              busy;
    logic              issued;
    logic              finish;

    // decode, master holds the address until done rises
    assign ram_hit      = (bus_addr >= ram_base) && (bus_addr < ram_limit);
    assign key_hit      = (bus_addr == key_addr);
    assign uart_hit     = (bus_addr == uart_addr);
    assign sdc_addr_hit = (bus_addr == sdc_addr_reg);
    assign sdc_read_hit = (bus_addr == sdc_read_reg);
    assign ready_hit    = (bus_addr == sdc_ready_reg);
    assign avail_hit    = (bus_addr == sdc_avail_reg);
    assign buf_off      = bus_addr - sdc_buf_base;
    assign buf_hit      = (bus_addr >= sdc_buf_base) &&
                          (bus_addr < sdc_buf_base + addr_w'(sector_bytes));
    assign buf_index    = buf_off[buf_idx_w-1:0];

    // an access is open while either done flag is low
    assign busy   = !bus_rd_done || !bus_wr_done;
    // registers finish one edge after issue, ram waits for its done pulse
    assign finish = issued && (!ram_hit || ram_done);

    // ram request, sampled by the ram on the issue edge
    assign ram_start = busy && !issued && ram_hit;
    assign ram_write = !bus_wr_done;
    assign ram_addr  = bus_addr[ram_addr_w-1:0];
    assign ram_type  = bus_ls_type;
    assign ram_wdata = bus_wdata;

    // register read mux, unmapped reads give zero
    always_comb begin
        reg_rdata = '0;
        if (key_hit) begin
            reg_rdata[7:0] = key_char;
        end else if (ready_hit) begin
            reg_rdata[0] = sd_ready;
        end else if (avail_hit) begin
            reg_rdata[0] = sector_avail;
        end else if (buf_hit) begin
            reg_rdata[7:0] = buf_byte;
        end
    end

    // handshake and register side effects
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_rd_done   <= 1'b1;
            bus_wr_done   <= 1'b1;
            issued        <= 1'b0;
            uart_valid    <= 1'b0;
            sd_read_start <= 1'b0;
            sd_sector     <= '0;
        end else begin
            // strobes are single cycle
            uart_valid    <= 1'b0;
            sd_read_start <= 1'b0;
            if (!busy) begin
                // read wins if both enables come together
                if (bus_rd_en) begin
                    bus_rd_done <= 1'b0;
                end else if (bus_wr_en) begin
                    bus_wr_done <= 1'b0;
                end
            end else if (!issued) begin
                issued <= 1'b1;
            end else if (finish) begin
                issued <= 1'b0;
                if (!bus_wr_done) begin
                    bus_wr_done <= 1'b1;
                    if (sdc_addr_hit) begin
                        sd_sector <= bus_wdata[31:0];
                    end
                    if (sdc_read_hit) begin
                        sd_read_start <= 1'b1;
                    end
                    if (uart_hit) begin
                        uart_valid <= 1'b1;
                    end
                end else begin
                    bus_rd_done <= 1'b1;
                end
            end
        end
    end

    // read data and console byte
    always_ff @(posedge CLOCK_50) begin
        if (finish && !bus_rd_done) begin
            bus_rdata <= ram_hit ? ram_rdata : reg_rdata;
        end
        if (finish && !bus_wr_done && uart_hit) begin
            uart_data <= bus_wdata[7:0];
        end
    end

endmodule

// File: ram_port.sv
`timescale 1ns/1ps

module ram_port import soc_pkg::*; (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  ram_start,
    input  logic                  ram_write,
    input  logic [ram_addr_w-1:0] ram_addr,
    input  ls_type_u              ram_type,
    input  logic [data_w-1:0]     ram_wdata,
    output logic [data_w-1:0]     ram_rdata,
    output logic                  ram_done
);

    logic [31:0]           mem [ram_words];
    logic [ram_addr_w-3:0] word_idx;
    logic [ram_addr_w-3:0] next_idx;
    logic [1:0]            off;
    logic                  is_double;
    logic                  beat2;
    logic [31:0]           cur_word;

    assign word_idx  = ram_addr[ram_addr_w-1:2];
    // upper half of a doubleword lives in the following word
    assign next_idx  = word_idx + 1'b1;
    assign off       = ram_addr[1:0];
    // size field only, so unsigned codes never take two beats
    assign is_double = (ram_type.f.size == size_double);
    assign cur_word  = mem[word_idx];

    // ram comes up cleared
    initial begin
        for (int i = 0; i < ram_words; i++) begin
            mem[i] = '0;
        end
    end

    // beat sequencing
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat2    <= 1'b0;
            ram_done <= 1'b0;
        end else begin
            ram_done <= 1'b0;
            beat2    <= 1'b0;
            if (ram_start) begin
                if (is_double) begin
                    beat2 <= 1'b1;
                end else begin
                    ram_done <= 1'b1;
                end
            end else if (beat2) begin
                ram_done <= 1'b1;
            end
        end
    end

    // array access
    always_ff @(posedge CLOCK_50) begin
        if (ram_start && ram_write) begin
            // stores decode the raw code
            case (ram_type.raw)
                3'd0: begin
                    mem[word_idx][{off, 3'b000} +: 8] <= ram_wdata[7:0];
                end
                3'd1: begin
                    // halfword only at offset 0 or 2
                    if (!off[0]) begin
                        mem[word_idx][{off[1], 4'b0000} +: 16] <= ram_wdata[15:0];
                    end
                end
                3'd2, 3'd3: begin
                    mem[word_idx] <= ram_wdata[31:0];
                end
                default: begin
                end
            endcase
        end else if (ram_start) begin
            if (is_double) begin
                // low word first
                ram_rdata <= {32'b0, cur_word};
            end else begin
                // narrowing is left to the cpu
                ram_rdata <= {32'b0, cur_word >> {off, 3'b000}};
            end
        end else if (beat2) begin
            if (ram_write) begin
                mem[next_idx] <= ram_wdata[63:32];
            end else begin
                ram_rdata[63:32] <= mem[next_idx];
            end
        end
    end

endmodule

// File: sector_buffer.sv
`timescale 1ns/1ps

module sector_buffer import soc_pkg::*; (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic [7:0]           sd_byte,
    input  logic                 sd_byte_valid,
    input  logic [buf_idx_w-1:0] buf_index,
    output logic [7:0]           buf_byte,
    output logic                 sector_avail
);

    logic [7:0]           buf_mem [sector_bytes];
    logic [buf_idx_w-1:0] fill_idx;
    logic                 valid_d;
    logic                 byte_edge;
    logic                 last_seen;

    // capture on the rising edge of the valid strobe
    assign byte_edge = sd_byte_valid && !valid_d;
    assign buf_byte  = buf_mem[buf_index];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            valid_d      <= 1'b0;
            fill_idx     <= '0;
            last_seen    <= 1'b0;
            sector_avail <= 1'b0;
        end else begin
            valid_d   <= sd_byte_valid;
            last_seen <= 1'b0;
            // flag follows the last byte by one edge
            if (last_seen) begin
                sector_avail <= 1'b1;
            end
            if (byte_edge) begin
                // index wraps back to 0 after byte 511
                fill_idx <= fill_idx + 1'b1;
                if (fill_idx == '1) begin
                    last_seen <= 1'b1;
                end
                // next sector has started
                if (fill_idx == '0) begin
                    sector_avail <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_edge) begin
            buf_mem[fill_idx] <= sd_byte;
        end
    end

endmodule

// File: key_irq.sv
`timescale 1ns/1ps

module key_irq (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] key_ascii,
    input  logic       key_pressed,
    input  logic       irq_ack,
    output logic [7:0] key_char,
    output logic [3:0] irq_vector
);

    logic key_d;
    logic key_edge;

    // one cycle on a new key press
    assign key_edge = key_pressed && !key_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_d      <= 1'b0;
            key_char   <= '0;
            irq_vector <= '0;
        end else begin
            key_d <= key_pressed;
            // ack only matters while a vector is pending
            if ((irq_vector != 4'd0) && irq_ack) begin
                irq_vector <= 4'd0;
            end
            if (key_edge) begin
                key_char <= key_ascii;
                // null character raises nothing
                if (key_ascii != 8'd0) begin
                    irq_vector <= 4'd1;
                end
            end
        end
    end

endmodule

// File: soc_pkg.sv
package soc_pkg;

    // bus widths
    localparam int addr_w = 64;
    localparam int data_w = 64;

    // on-chip ram, organised as 32-bit words
    localparam int ram_words  = 3072;
    // byte address bits seen by the ram
    localparam int ram_addr_w = 14;

    // sd sector buffer
    localparam int sector_bytes = 512;
    localparam int buf_idx_w    = 9;

    // address map
    localparam logic [addr_w-1:0] ram_base      = 64'h0000;
    localparam logic [addr_w-1:0] ram_limit     = 64'h3000;
    localparam logic [addr_w-1:0] key_addr      = 64'h8000;
    localparam logic [addr_w-1:0] uart_addr     = 64'h8008;
    localparam logic [addr_w-1:0] sdc_addr_reg  = 64'h8010;
    localparam logic [addr_w-1:0] sdc_read_reg  = 64'h8018;
    localparam logic [addr_w-1:0] sdc_ready_reg = 64'h8020;
    localparam logic [addr_w-1:0] sdc_avail_reg = 64'h8028;
    // 512 byte window starts here
    localparam logic [addr_w-1:0] sdc_buf_base  = 64'h9000;

    // size field value of a doubleword access
    localparam logic [1:0] size_double = 2'd3;

    // load/store type
    // raw 0..3 byte, half, word, double
    // raw 4..6 unsigned byte, half, word loads
    typedef union packed {
        logic [2:0] raw;
        struct packed {
            // top bit marks the unsigned loads
            logic       unsigned_ld;
            // low two bits give the access size
            logic [1:0] size;
        } f;
    } ls_type_u;

endpackage
